//--- source/rename_consts.svh
// rename / dispatch sizing constants
// architectural and physical register counts, ROB depth, free list depth

`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// ================================================
// register file sizes
// ================================================
`define ARCH_REGS   32                          // rv32i x0..x31
`define PHYS_REGS   40                          // physical register file

// ================================================
// queue depths
// ================================================
`define ROB_DEPTH   16                          // reorder buffer entries
`define FREE_REGS   (`PHYS_REGS - `ARCH_REGS)   // free list capacity, 8

`endif

//--- source/rename_pkg.sv
// rename package
// shared types for the rename and dispatch front end

`include "rename_consts.svh"

package rename_pkg;

    // ================================================
    // index and tag widths
    // ================================================
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;   // 5 bits
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_tag_t;   // 6 bits
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;    // 4 bits

    typedef logic [31:0] inst_t;                         // raw instruction word

    // functional unit class, same encoding as the rs side
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MULT   = 2'd1,
        FU_MEM    = 2'd2,
        FU_BRANCH = 2'd3
    } fu_type_e;

    // dispatch control state
    typedef enum logic {
        CTRL_RESET = 1'b0,   // first cycle out of reset, nothing dispatches
        CTRL_RUN   = 1'b1
    } ctrl_state_e;

endpackage

//--- source/inst_decoder.sv
// instruction decoder
// pulls register fields out of an rv32i word and sorts it by unit class

`timescale 1ns/1ps

module inst_decoder (
    input  rename_pkg::inst_t     inst_i,
    output rename_pkg::arch_reg_t rs1_o,
    output rename_pkg::arch_reg_t rs2_o,
    output rename_pkg::arch_reg_t rd_o,
    output logic                  has_dest_o,
    output logic                  is_mem_o,
    output logic                  is_store_o,
    output logic                  is_branch_o,
    output logic                  illegal_o,
    output rename_pkg::fu_type_e  fu_type_o
);
    import rename_pkg::*;

    // base opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic       writes_rd;   // opcode writes rd at all

    assign opcode = inst_i[6:0];
    assign funct7 = inst_i[31:25];

    // fields are passed on raw, unused ones are don't-care downstream
    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];
    assign rd_o  = inst_i[11:7];

    always_comb begin
        writes_rd   = 1'b0;
        is_mem_o    = 1'b0;
        is_store_o  = 1'b0;
        is_branch_o = 1'b0;
        illegal_o   = 1'b0;
        fu_type_o   = FU_ALU;
        case (opcode)
            OP_LUI, OP_AUIPC, OP_IMM: writes_rd = 1'b1;
            OP_JAL, OP_JALR: begin
                writes_rd   = 1'b1;   // link register
                is_branch_o = 1'b1;
                fu_type_o   = FU_BRANCH;
            end
            OP_BRANCH: begin
                is_branch_o = 1'b1;
                fu_type_o   = FU_BRANCH;
            end
            OP_LOAD: begin
                writes_rd = 1'b1;
                is_mem_o  = 1'b1;
                fu_type_o = FU_MEM;
            end
            OP_STORE: begin
                is_mem_o   = 1'b1;
                is_store_o = 1'b1;
                fu_type_o  = FU_MEM;
            end
            OP_REG: begin
                if (funct7 == 7'b0000001) begin   // m extension
                    writes_rd = 1'b1;
                    fu_type_o = FU_MULT;
                end else if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
                    writes_rd = 1'b1;
                end else begin
                    illegal_o = 1'b1;
                end
            end
            default: illegal_o = 1'b1;   // unknown, flagged only
        endcase
    end

    assign has_dest_o = writes_rd && (rd_o != '0);   // x0 never renamed

endmodule

//--- source/map_table.sv
// register map table
// architectural to physical mapping, two source reads, old tag read, one write

`timescale 1ns/1ps

`include "rename_consts.svh"

module map_table (
    input  logic                  clock,
    input  logic                  reset,
    input  rename_pkg::arch_reg_t src1_arch_i,
    input  rename_pkg::arch_reg_t src2_arch_i,
    input  rename_pkg::arch_reg_t dest_arch_i,
    input  logic                  rename_we_i,
    input  rename_pkg::phys_tag_t new_tag_i,
    output rename_pkg::phys_tag_t src1_tag_o,
    output rename_pkg::phys_tag_t src2_tag_o,
    output rename_pkg::phys_tag_t old_tag_o
);
    import rename_pkg::*;

    phys_tag_t map_q [`ARCH_REGS];

    // reads see the table before this cycle's write
    assign src1_tag_o = map_q[src1_arch_i];
    assign src2_tag_o = map_q[src2_arch_i];
    assign old_tag_o  = map_q[dest_arch_i];   // Told for the rob

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);   // identity map
            end
        end else if (rename_we_i && dest_arch_i != '0) begin
            map_q[dest_arch_i] <= new_tag_i;
        end
    end

    // ================================================
    // checks
    // ================================================
    // the decoder drops x0 destinations before the control raises a write
    a_no_x0_write: assert property (
        @(posedge clock) disable iff (reset)
        rename_we_i |-> dest_arch_i != '0
    ) else $error("map table write to x0");

endmodule

//--- source/free_list.sv
// free list
// circular fifo of unmapped physical tags, head tag always on the output

`timescale 1ns/1ps

`include "rename_consts.svh"

module free_list (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  alloc_i,      // pop head
    input  logic                  free_i,       // push retired tag
    input  rename_pkg::phys_tag_t free_tag_i,
    output rename_pkg::phys_tag_t head_tag_o,
    output logic                  empty_o
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(`FREE_REGS);
    localparam int CNT_W = $clog2(`FREE_REGS + 1);

    phys_tag_t        tags_q [`FREE_REGS];
    logic [PTR_W-1:0] head_q;     // next tag handed out
    logic [PTR_W-1:0] tail_q;     // next slot for a returned tag
    logic [CNT_W-1:0] count_q;
    logic             full;

    assign head_tag_o = tags_q[head_q];
    assign empty_o    = (count_q == '0);
    assign full       = (count_q == CNT_W'(`FREE_REGS));

    // depth is a power of two, pointers wrap on their own
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `FREE_REGS; i++) begin
                tags_q[i] <= phys_tag_t'(`ARCH_REGS + i);   // tags 32..39
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= CNT_W'(`FREE_REGS);   // starts full
        end else begin
            if (free_i) begin
                tags_q[tail_q] <= free_tag_i;
                tail_q         <= tail_q + 1'b1;
            end
            if (alloc_i) begin
                head_q <= head_q + 1'b1;
            end
            case ({free_i, alloc_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // both or neither
            endcase
        end
    end

    // ================================================
    // checks
    // ================================================
    a_no_alloc_empty: assert property (
        @(posedge clock) disable iff (reset) alloc_i |-> !empty_o
    ) else $error("free list allocation while empty");

    // 40 tags total, so a full list means no valid Told sits in the rob
    a_no_push_full: assert property (
        @(posedge clock) disable iff (reset) free_i |-> !full
    ) else $error("free list push while full");

endmodule

//--- source/rob_alloc.sv
// rob slot allocator
// hands out tail indices, keeps Told per entry, releases it on retire

`timescale 1ns/1ps

`include "rename_consts.svh"

module rob_alloc (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  push_i,
    input  rename_pkg::phys_tag_t old_tag_i,
    input  logic                  has_dest_i,
    input  logic                  retire_i,
    output rename_pkg::rob_idx_t  tail_idx_o,
    output logic                  full_o,
    output logic                  free_o,        // head Told goes back
    output rename_pkg::phys_tag_t freed_tag_o
);
    import rename_pkg::*;

    localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

    phys_tag_t              old_tag_q [`ROB_DEPTH];   // payload, no reset
    logic [`ROB_DEPTH-1:0]  dest_vld_q;               // entry holds a real Told
    rob_idx_t               head_q;
    rob_idx_t               tail_q;
    logic [CNT_W-1:0]       count_q;

    assign tail_idx_o  = tail_q;
    assign full_o      = (count_q == CNT_W'(`ROB_DEPTH));
    assign freed_tag_o = old_tag_q[head_q];
    assign free_o      = retire_i && dest_vld_q[head_q];   // no-dest entries free nothing

    always_ff @(posedge clock) begin
        if (push_i) begin
            old_tag_q[tail_q] <= has_dest_i ? old_tag_i : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            dest_vld_q <= '0;
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
        end else begin
            if (push_i) begin
                dest_vld_q[tail_q] <= has_dest_i;
                tail_q             <= tail_q + 1'b1;   // wraps 15 -> 0
            end
            if (retire_i) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(retire_i);
        end
    end

    // ================================================
    // checks
    // ================================================
    a_no_retire_empty: assert property (
        @(posedge clock) disable iff (reset) retire_i |-> count_q != '0
    ) else $error("retire with an empty rob");

endmodule

//--- source/dispatch_ctrl.sv
// dispatch control
// forms the one fire condition and gates every enable and strobe with it

`timescale 1ns/1ps

module dispatch_ctrl (
    input  logic clock,
    input  logic reset,
    input  logic inst_valid_i,
    input  logic branch_stall_i,   // held by the branch side
    input  logic rs_full_i,        // level from the reservation stations
    input  logic has_dest_i,
    input  logic is_mem_i,
    input  logic is_branch_i,
    input  logic rob_full_i,
    input  logic free_empty_i,
    output logic alloc_o,          // free list pop
    output logic rename_we_o,      // map table write
    output logic rob_push_o,
    output logic dispatch_o,
    output logic stall_o,
    output logic lsq_valid_o,
    output logic branch_o
);
    import rename_pkg::*;

    ctrl_state_e state_q;
    logic        running;
    logic        resources_ok;   // rob slot and, if needed, a tag
    logic        fire;

    // ================================================
    // state
    // ================================================
    // one idle cycle after reset so the tables settle
    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= CTRL_RESET;
        end else begin
            state_q <= CTRL_RUN;
        end
    end

    assign running = (state_q == CTRL_RUN);

    // ================================================
    // fire and enables
    // ================================================
    assign resources_ok = !rob_full_i && !(has_dest_i && free_empty_i);

    assign fire = running && inst_valid_i
               && !branch_stall_i && !rs_full_i
               && resources_ok;

    assign alloc_o     = fire && has_dest_i;
    assign rename_we_o = fire && has_dest_i;   // same value as the pop
    assign rob_push_o  = fire;
    assign dispatch_o  = fire;
    assign stall_o     = running && inst_valid_i && !fire;   // instruction held at input
    assign lsq_valid_o = fire && is_mem_i;
    assign branch_o    = fire && is_branch_i;

    // ================================================
    // checks
    // ================================================
    // a stalled instruction stays on the input, same decode, until it goes
    a_stall_hold: assert property (
        @(posedge clock) disable iff (reset)
        stall_o |=> inst_valid_i && $stable({has_dest_i, is_mem_i, is_branch_i})
    ) else $error("stalled instruction not held at the input");

endmodule

//--- source/rename_dispatch_top.sv
// rename and dispatch top level
// decoder, map table, free list and rob allocator around one control block

`timescale 1ns/1ps

module rename_dispatch_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  inst_valid_i,
    input  rename_pkg::inst_t     inst_i,
    input  logic                  branch_stall_i,
    input  logic                  rs_full_i,
    input  logic                  retire_i,
    output logic                  dispatch_o,
    output logic                  stall_o,
    output rename_pkg::rob_idx_t  rob_idx_o,
    output rename_pkg::phys_tag_t dest_tag_o,
    output rename_pkg::phys_tag_t old_tag_o,
    output rename_pkg::phys_tag_t src1_tag_o,
    output rename_pkg::phys_tag_t src2_tag_o,
    output rename_pkg::fu_type_e  fu_type_o,
    output logic                  lsq_valid_o,
    output logic                  is_store_o,
    output logic                  is_branch_o,
    output logic                  illegal_o
);
    import rename_pkg::*;

    arch_reg_t rs1, rs2, rd;
    logic      has_dest, is_mem, is_branch;
    logic      alloc, rename_we, rob_push;
    logic      free_empty, rob_full;
    logic      tag_free;          // rob returns a Told
    phys_tag_t head_tag, freed_tag;

    inst_decoder u_decoder (
        .inst_i (inst_i), .rs1_o (rs1), .rs2_o (rs2), .rd_o (rd),
        .has_dest_o (has_dest), .is_mem_o (is_mem), .is_store_o (is_store_o),
        .is_branch_o (is_branch), .illegal_o (illegal_o), .fu_type_o (fu_type_o)
    );

    map_table u_map (
        .clock (clock), .reset (reset),
        .src1_arch_i (rs1), .src2_arch_i (rs2), .dest_arch_i (rd),
        .rename_we_i (rename_we), .new_tag_i (head_tag),
        .src1_tag_o (src1_tag_o), .src2_tag_o (src2_tag_o), .old_tag_o (old_tag_o)
    );

    free_list u_free (
        .clock (clock), .reset (reset), .alloc_i (alloc),
        .free_i (tag_free), .free_tag_i (freed_tag),
        .head_tag_o (head_tag), .empty_o (free_empty)
    );

    rob_alloc u_rob (
        .clock (clock), .reset (reset), .push_i (rob_push),
        .old_tag_i (old_tag_o), .has_dest_i (has_dest), .retire_i (retire_i),
        .tail_idx_o (rob_idx_o), .full_o (rob_full),
        .free_o (tag_free), .freed_tag_o (freed_tag)
    );

    dispatch_ctrl u_ctrl (
        .clock (clock), .reset (reset),
        .inst_valid_i (inst_valid_i), .branch_stall_i (branch_stall_i),
        .rs_full_i (rs_full_i), .has_dest_i (has_dest), .is_mem_i (is_mem),
        .is_branch_i (is_branch), .rob_full_i (rob_full), .free_empty_i (free_empty),
        .alloc_o (alloc), .rename_we_o (rename_we), .rob_push_o (rob_push),
        .dispatch_o (dispatch_o), .stall_o (stall_o),
        .lsq_valid_o (lsq_valid_o), .branch_o (is_branch_o)
    );

    assign dest_tag_o = has_dest ? head_tag : '0;   // no tag taken without a dest

endmodule

//--- sim/rename_dispatch_tb.sv
// rename / dispatch testbench
// replays the case file one line per cycle and checks every dispatch output

`timescale 1ns/1ps

module rename_dispatch_tb;
    import rename_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_CASES    = 256;
    localparam int NUM_FIELDS   = 16;   // 5 stimulus + 11 expected columns

    logic      clock;
    logic      reset;
    logic      inst_valid;
    inst_t     inst;
    logic      branch_stall;
    logic      rs_full;
    logic      retire;
    logic      dispatch;
    logic      stall;
    rob_idx_t  rob_idx;
    phys_tag_t dest_tag;
    phys_tag_t old_tag;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    fu_type_e  fu_type;
    logic      lsq_valid;
    logic      is_store;
    logic      is_branch;
    logic      illegal;

    logic [31:0] cases [MAX_CASES][NUM_FIELDS];
    int          num_cases   = 0;
    int          case_idx    = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;   // armed once the cases are loaded

    rename_dispatch_top UUT (
        .clock          (clock),
        .reset          (reset),
        .inst_valid_i   (inst_valid),
        .inst_i         (inst),
        .branch_stall_i (branch_stall),
        .rs_full_i      (rs_full),
        .retire_i       (retire),
        .dispatch_o     (dispatch),
        .stall_o        (stall),
        .rob_idx_o      (rob_idx),
        .dest_tag_o     (dest_tag),
        .old_tag_o      (old_tag),
        .src1_tag_o     (src1_tag),
        .src2_tag_o     (src2_tag),
        .fu_type_o      (fu_type),
        .lsq_valid_o    (lsq_valid),
        .is_store_o     (is_store),
        .is_branch_o    (is_branch),
        .illegal_o      (illegal)
    );

    // ================================================
    // clock and watchdog
    // ================================================
    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the case list did not finish within %0d cycles", cycle_count);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    // ================================================
    // compare tasks
    // ================================================
    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: case %0d %s = 0x%h, expected 0x%h", case_idx, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_tag(input string name, input phys_tag_t got, input phys_tag_t exp);
        if (got !== exp) begin
            $display("** Error: case %0d %s = 0x%h, expected 0x%h", case_idx, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_rob(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) begin
            $display("** Error: case %0d %s = 0x%h, expected 0x%h", case_idx, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_fu(input string name, input fu_type_e got, input fu_type_e exp);
        if (got !== exp) begin
            $display("** Error: case %0d %s = 0x%h, expected 0x%h", case_idx, name, got, exp);
            abort_run();
        end
    endtask

    // ================================================
    // case file
    // ================================================
    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] row [NUM_FIELDS];
        fd = $fopen("sim/dispatch_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file sim/dispatch_cases.txt");
            abort_run();
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;   // blank or column notes
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            row[0], row[1], row[2], row[3], row[4], row[5], row[6], row[7],
                            row[8], row[9], row[10], row[11], row[12], row[13], row[14],
                            row[15]);
                if (n != NUM_FIELDS || num_cases == MAX_CASES) begin
                    $display("case %0d in the case file is malformed or one too many", num_cases);
                    abort_run();
                end else begin
                    for (int k = 0; k < NUM_FIELDS; k++) begin
                        cases[num_cases][k] = row[k];
                    end
                    num_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_case(input int i);
        inst_valid   <= cases[i][0][0];
        inst         <= cases[i][1];
        branch_stall <= cases[i][2][0];
        rs_full      <= cases[i][3][0];
        retire       <= cases[i][4][0];
    endtask

    task automatic check_case(input int i);
        check_bit("dispatch_o", dispatch, cases[i][5][0]);
        check_bit("stall_o", stall, cases[i][6][0]);
        check_rob("rob_idx_o", rob_idx, rob_idx_t'(cases[i][7]));
        check_tag("dest_tag_o", dest_tag, phys_tag_t'(cases[i][8]));
        check_tag("old_tag_o", old_tag, phys_tag_t'(cases[i][9]));
        check_tag("src1_tag_o", src1_tag, phys_tag_t'(cases[i][10]));
        check_tag("src2_tag_o", src2_tag, phys_tag_t'(cases[i][11]));
        check_fu("fu_type_o", fu_type, fu_type_e'(cases[i][12][1:0]));
        check_bit("lsq_valid_o", lsq_valid, cases[i][13][0]);
        check_bit("is_store_o", is_store, cases[i][14][0]);
        check_bit("is_branch_o", is_branch, cases[i][15][0]);
        check_bit("illegal_o", illegal, 1'b0);   // every case is a legal rv32im op
    endtask

    // ================================================
    // main sequence
    // ================================================
    initial begin : run
        reset        <= 1'b1;
        inst_valid   <= 1'b0;
        inst         <= '0;
        branch_stall <= 1'b0;
        rs_full      <= 1'b0;
        retire       <= 1'b0;
        load_cases();
        cycle_limit = num_cases + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;   // case 0 lands in the idle control cycle
        for (case_idx = 0; case_idx < num_cases; case_idx++) begin
            if (case_idx != 0) begin
                @(posedge clock);
            end
            apply_case(case_idx);
            #(CLK_PERIOD - 1);   // sample just ahead of the next edge
            check_case(case_idx);
        end
        $display("Test passed");
        $finish;
    end

endmodule

//--- sim/dispatch_cases.txt
# valid inst bstall rsfull retire | dispatch stall rob dest old src1 src2 fu lsq store branch
# all hex, one line per cycle, line 0 falls in the idle control cycle after reset
1 003100b3 0 0 0 0 0 0 20 01 02 03 0 0 0 0
1 003100b3 0 0 0 1 0 0 20 01 02 03 0 0 0 0
1 00108133 0 0 0 1 0 1 21 02 20 20 0 0 0 0
1 021101b3 0 0 0 1 0 2 22 03 21 20 1 0 0 0
1 00118033 0 0 0 1 0 3 00 00 22 20 0 0 0 0
1 00312223 0 0 0 1 0 4 00 04 21 22 2 1 1 0
1 00208463 0 0 0 1 0 5 00 08 20 21 3 0 0 1
1 0000a203 1 0 0 0 1 6 23 04 20 00 2 0 0 0
1 0000a203 0 1 0 0 1 6 23 04 20 00 2 0 0 0
1 0000a203 0 0 0 1 0 6 23 04 20 00 2 1 0 0
1 003202b3 0 0 0 1 0 7 24 05 23 22 0 0 0 0
1 00428333 0 0 0 1 0 8 25 06 24 23 0 0 0 0
1 005300b3 0 0 0 1 0 9 26 20 25 24 0 0 0 0
1 00608133 0 0 0 1 0 a 27 21 26 25 0 0 0 0
1 001103b3 0 0 0 0 1 b 20 07 27 26 0 0 0 0
1 001103b3 0 0 1 0 1 b 20 07 27 26 0 0 0 0
1 001103b3 0 0 0 1 0 b 01 07 27 26 0 0 0 0
1 00312223 0 0 0 1 0 c 00 23 27 22 2 1 1 0
1 00208463 0 0 0 1 0 d 00 08 26 27 3 0 0 1
1 00118033 0 0 0 1 0 e 00 00 22 26 0 0 0 0
1 00312223 0 0 0 1 0 f 00 23 27 22 2 1 1 0
1 00208463 0 0 0 1 0 0 00 08 26 27 3 0 0 1
1 00118033 0 0 0 0 1 1 00 00 22 26 0 0 0 0
1 00118033 0 0 1 0 1 1 00 00 22 26 0 0 0 0
1 00118033 0 0 1 1 0 1 00 00 22 26 0 0 0 0
1 00038433 0 0 0 1 0 2 02 08 01 00 0 0 0 0

//--- src.f
+incdir+source
source/rename_pkg.sv
source/inst_decoder.sv
source/map_table.sv
source/free_list.sv
source/rob_alloc.sv
source/dispatch_ctrl.sv
source/rename_dispatch_top.sv
sim/rename_dispatch_tb.sv

//--- Makefile
# Verilator build and run of the rename / dispatch testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= rename_dispatch_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_TEXT ?= Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
